// File: build.f
pcs_block_pkg.sv
rx_status_pkg.sv
lane_block_sync.sv
idle_pattern_checker.sv
rx_status_registers.sv
pcs_rx_monitor_top.sv
tb_clock_gen.sv
tb_pcs_rx_monitor.sv

// File: idle_pattern_checker.sv
// compares payloads only, headers are left to block sync; no strobe while idle mode is off
module idle_pattern_checker
    import pcs_block_pkg::*;
#(
    parameter  int N_LANES       = 4,
    localparam int NB_LANE_COUNT = $clog2(N_LANES + 1)
)
(
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_valid,
    input  logic                     i_idle_pattern_mode,
    input  block_t [N_LANES-1:0]     i_phy_data,
    output logic [NB_LANE_COUNT-1:0] o_mismatch_lanes,
    output logic                     o_mismatch_valid
);

    logic [NB_LANE_COUNT-1:0] lane_count;

    // number of lanes whose payload is not an idle block
    always_comb
    begin
        lane_count = '0;
        for (int lane = 0; lane < N_LANES; lane++)
        begin
            if (i_phy_data[lane].payload != IDLE_PAYLOAD)
            begin
                lane_count = lane_count + 1'b1;
            end
        end
    end

    // one-cycle strobe per checked block
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_mismatch_valid <= 1'b0;
        end
        else
        begin
            o_mismatch_valid <= i_valid && i_idle_pattern_mode;
        end
    end

    // count is only meaningful together with the strobe
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            o_mismatch_lanes <= lane_count;
        end
    end

endmodule

// File: lane_block_sync.sv
// judges header validity only, no bit slipping; input must already be block-aligned per lane
module lane_block_sync
    import pcs_block_pkg::*;
#(
    parameter int LOCK_BLOCKS   = 16,
    parameter int WINDOW_BLOCKS = 64,
    parameter int INVALID_LIMIT = 8
)
(
    input  logic   i_clock,
    input  logic   i_reset,
    input  logic   i_valid,
    input  logic   i_signal_ok,
    input  block_t i_block,
    output logic   o_block_lock
);

    localparam int NB_LOCK_COUNT    = $clog2(LOCK_BLOCKS + 1);
    localparam int NB_WINDOW_COUNT  = $clog2(WINDOW_BLOCKS + 1);
    localparam int NB_INVALID_COUNT = $clog2(INVALID_LIMIT + 1);

    // last count value before each threshold is reached
    localparam logic [NB_LOCK_COUNT-1:0]    LOCK_LAST    = NB_LOCK_COUNT'(LOCK_BLOCKS - 1);
    localparam logic [NB_WINDOW_COUNT-1:0]  WINDOW_LAST  = NB_WINDOW_COUNT'(WINDOW_BLOCKS - 1);
    localparam logic [NB_INVALID_COUNT-1:0] INVALID_LAST = NB_INVALID_COUNT'(INVALID_LIMIT - 1);

    logic                        header_ok;
    logic [NB_LOCK_COUNT-1:0]    valid_count;
    logic [NB_WINDOW_COUNT-1:0]  window_count;
    logic [NB_INVALID_COUNT-1:0] invalid_count;

    assign header_ok = (i_block.sync_header == SH_DATA) || (i_block.sync_header == SH_CTRL);

    always_ff @(posedge i_clock)
    begin
        // loss of signal behaves like a reset of the lock logic
        if (i_reset || !i_signal_ok)
        begin
            o_block_lock  <= 1'b0;
            valid_count   <= '0;
            window_count  <= '0;
            invalid_count <= '0;
        end
        else if (i_valid)
        begin
            if (!o_block_lock)
            begin
                // hunting for consecutive good headers
                if (!header_ok)
                begin
                    valid_count <= '0;
                end
                else if (valid_count == LOCK_LAST)
                begin
                    o_block_lock <= 1'b1;
                    valid_count  <= '0;
                end
                else
                begin
                    valid_count <= valid_count + 1'b1;
                end
            end
            else
            begin
                // locked, watch invalid headers per window
                if (!header_ok && (invalid_count == INVALID_LAST))
                begin
                    o_block_lock  <= 1'b0;
                    window_count  <= '0;
                    invalid_count <= '0;
                end
                else if (window_count == WINDOW_LAST)
                begin
                    window_count  <= '0;
                    invalid_count <= '0;
                end
                else
                begin
                    window_count <= window_count + 1'b1;
                    if (!header_ok)
                    begin
                        invalid_count <= invalid_count + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: pcs_block_pkg.sv
// blocks arrive block-aligned with the sync header in bits 65:64; payload byte order is not swapped
package pcs_block_pkg;

    // block geometry
    localparam int NB_BLOCK       = 66;
    localparam int NB_SYNC_HEADER = 2;
    localparam int NB_PAYLOAD     = NB_BLOCK - NB_SYNC_HEADER;

    typedef logic [NB_SYNC_HEADER-1:0] sync_header_t;
    typedef logic [NB_PAYLOAD-1:0]     payload_t;

    // the only two legal sync headers
    localparam sync_header_t SH_DATA = 2'b01;
    localparam sync_header_t SH_CTRL = 2'b10;

    // block type byte of an idle control block
    localparam logic [7:0] IDLE_BLOCK_TYPE = 8'h1E;

    // idle control block payload, type byte on top and all control codes zero
    localparam payload_t IDLE_PAYLOAD = {IDLE_BLOCK_TYPE, {(NB_PAYLOAD - 8){1'b0}}};

    // one 66-bit block, header first so it lands in the top two bits
    typedef struct packed
    {
        sync_header_t sync_header;
        payload_t     payload;
    } block_t;

endpackage

// File: pcs_rx_monitor_top.sv
// receive monitor only, blocks pass through nowhere; lane k of i_phy_data is block k, no stall
module pcs_rx_monitor_top
    import pcs_block_pkg::*;
    import rx_status_pkg::*;
#(
    parameter int N_LANES       = 4,
    parameter int LOCK_BLOCKS   = 16,
    parameter int WINDOW_BLOCKS = 64,
    parameter int INVALID_LIMIT = 8
)
(
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_valid,
    input  block_t [N_LANES-1:0] i_phy_data,
    input  logic                 i_signal_ok,
    input  logic                 i_idle_pattern_mode,
    input  logic                 i_read_lock_status,
    input  logic                 i_read_mismatch,
    output logic [N_LANES-1:0]   o_lane_lock,
    output logic [N_LANES-1:0]   o_lock_status,
    output mismatch_count_t      o_mismatch_count,
    output logic                 o_rx_ok
);

    localparam int NB_LANE_COUNT = $clog2(N_LANES + 1);

    logic [N_LANES-1:0]       lane_lock;
    logic [NB_LANE_COUNT-1:0] mismatch_lanes;
    logic                     mismatch_valid;

    // one lock machine per lane
    for (genvar g_lane = 0; g_lane < N_LANES; g_lane++)
    begin : g_lane_sync
        lane_block_sync
        #(
            .LOCK_BLOCKS   (LOCK_BLOCKS),
            .WINDOW_BLOCKS (WINDOW_BLOCKS),
            .INVALID_LIMIT (INVALID_LIMIT)
        )
        u_lane_block_sync
        (
            .i_clock      (i_clock),
            .i_reset      (i_reset),
            .i_valid      (i_valid),
            .i_signal_ok  (i_signal_ok),
            .i_block      (i_phy_data[g_lane]),
            .o_block_lock (lane_lock[g_lane])
        );
    end

    idle_pattern_checker
    #(
        .N_LANES (N_LANES)
    )
    u_idle_pattern_checker
    (
        .i_clock             (i_clock),
        .i_reset             (i_reset),
        .i_valid             (i_valid),
        .i_idle_pattern_mode (i_idle_pattern_mode),
        .i_phy_data          (i_phy_data),
        .o_mismatch_lanes    (mismatch_lanes),
        .o_mismatch_valid    (mismatch_valid)
    );

    rx_status_registers
    #(
        .N_LANES (N_LANES)
    )
    u_rx_status_registers
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_lane_lock        (lane_lock),
        .i_mismatch_lanes   (mismatch_lanes),
        .i_mismatch_valid   (mismatch_valid),
        .i_read_lock_status (i_read_lock_status),
        .i_read_mismatch    (i_read_mismatch),
        .o_lock_status      (o_lock_status),
        .o_mismatch_count   (o_mismatch_count),
        .o_rx_ok            (o_rx_ok)
    );

    // live lock, no status latching
    assign o_lane_lock = lane_lock;

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
    --top-module tb_pcs_rx_monitor --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
grep -q "Verification passed" sim.log

// File: rx_status_pkg.sv
// status counters saturate at all ones and are only cleared by a read edge or reset
package rx_status_pkg;

    // width of the payload mismatch counter
    localparam int NB_MISMATCH_COUNTER = 16;

    typedef logic [NB_MISMATCH_COUNTER-1:0] mismatch_count_t;

    // value where the counter stops
    localparam mismatch_count_t MISMATCH_COUNT_MAX = '1;

endpackage

// File: rx_status_registers.sv
// clear-on-read acts on the rising edge of each read input only, a held read clears once
module rx_status_registers
    import rx_status_pkg::*;
#(
    parameter  int N_LANES       = 4,
    localparam int NB_LANE_COUNT = $clog2(N_LANES + 1)
)
(
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic [N_LANES-1:0]       i_lane_lock,
    input  logic [NB_LANE_COUNT-1:0] i_mismatch_lanes,
    input  logic                     i_mismatch_valid,
    input  logic                     i_read_lock_status,
    input  logic                     i_read_mismatch,
    output logic [N_LANES-1:0]       o_lock_status,
    output mismatch_count_t          o_mismatch_count,
    output logic                     o_rx_ok
);

    logic                         read_lock_status_d;
    logic                         read_mismatch_d;
    logic                         read_lock_status_edge;
    logic                         read_mismatch_edge;
    logic [NB_MISMATCH_COUNTER:0] mismatch_addend;
    logic [NB_MISMATCH_COUNTER:0] mismatch_sum;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            read_lock_status_d <= 1'b0;
            read_mismatch_d    <= 1'b0;
        end
        else
        begin
            read_lock_status_d <= i_read_lock_status;
            read_mismatch_d    <= i_read_mismatch;
        end
    end

    assign read_lock_status_edge = i_read_lock_status && !read_lock_status_d;
    assign read_mismatch_edge    = i_read_mismatch && !read_mismatch_d;

    // this cycle's contribution, zero without a strobe
    assign mismatch_addend = i_mismatch_valid ?
        {{(NB_MISMATCH_COUNTER + 1 - NB_LANE_COUNT){1'b0}}, i_mismatch_lanes} : '0;
    // extra top bit is the overflow flag
    assign mismatch_sum    = {1'b0, o_mismatch_count} + mismatch_addend;

    // latched low until the next read
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_lock_status <= '0;
        end
        else if (read_lock_status_edge)
        begin
            o_lock_status <= i_lane_lock;
        end
        else
        begin
            o_lock_status <= o_lock_status & i_lane_lock;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_mismatch_count <= '0;
        end
        else if (read_mismatch_edge)
        begin
            // restart from what arrived in the read cycle
            o_mismatch_count <= mismatch_addend[NB_MISMATCH_COUNTER-1:0];
        end
        else if (mismatch_sum[NB_MISMATCH_COUNTER])
        begin
            o_mismatch_count <= MISMATCH_COUNT_MAX;
        end
        else
        begin
            o_mismatch_count <= mismatch_sum[NB_MISMATCH_COUNTER-1:0];
        end
    end

    assign o_rx_ok = (&o_lock_status) && (o_mismatch_count == '0);

endmodule

// File: tb_clock_gen.sv
// period must be an even number of ns; reset drops with a non-blocking write on a rising edge
module tb_clock_gen
#(
    parameter int CLOCK_PERIOD = 40,
    parameter int RESET_CYCLES = 2
)
(
    output logic o_clock,
    output logic o_reset
);

    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        o_clock = 1'b0;
    end

    always #(CLOCK_PERIOD / 2) o_clock = ~o_clock;

    // reset held over the first rising edges
    initial
    begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clock);
        o_reset <= 1'b0;
    end

endmodule

// File: tb_pcs_rx_monitor.sv
// parameters must match what the DUT is built with; stimulus repeats exactly for the fixed seed
module tb_pcs_rx_monitor
    import pcs_block_pkg::*;
    import rx_status_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          N_LANES       = 4;
    localparam int          LOCK_BLOCKS   = 16;
    localparam int          WINDOW_BLOCKS = 64;
    localparam int          INVALID_LIMIT = 8;
    localparam int          COUNT_MAX     = 65535;
    // tests take about 3600 cycles
    localparam int          CYCLE_LIMIT   = 5000;
    localparam logic [63:0] IDLE_WORD     = 64'h1E00_0000_0000_0000;
    localparam logic [31:0] LFSR_SEED     = 32'h006d_6312;

    logic                 clock;
    logic                 reset;
    logic                 i_valid;
    block_t [N_LANES-1:0] i_phy_data;
    logic                 i_signal_ok;
    logic                 i_idle_pattern_mode;
    logic                 i_read_lock_status;
    logic                 i_read_mismatch;
    logic [N_LANES-1:0]   o_lane_lock;
    logic [N_LANES-1:0]   o_lock_status;
    mismatch_count_t      o_mismatch_count;
    logic                 o_rx_ok;

    // levels for the next driven cycle
    logic        stim_signal_ok;
    logic        stim_idle_mode;
    logic        stim_read_lock;
    logic        stim_read_mismatch;
    logic [31:0] lfsr_state;
    int          cycle_count = 0;
    string       test_name;

    // reference model state
    logic [N_LANES-1:0] m_lock;
    logic [N_LANES-1:0] m_lock_status;
    int                 m_valid_count [N_LANES];
    int                 m_window_count [N_LANES];
    int                 m_invalid_count [N_LANES];
    logic               m_chk_valid;
    int                 m_chk_lanes;
    int                 m_count;
    logic               m_read_lock_d;
    logic               m_read_mismatch_d;

    tb_clock_gen u_clock_gen
    (
        .o_clock (clock),
        .o_reset (reset)
    );

    pcs_rx_monitor_top
    #(
        .N_LANES       (N_LANES),
        .LOCK_BLOCKS   (LOCK_BLOCKS),
        .WINDOW_BLOCKS (WINDOW_BLOCKS),
        .INVALID_LIMIT (INVALID_LIMIT)
    )
    i_dut
    (
        .i_clock             (clock),
        .i_reset             (reset),
        .i_valid             (i_valid),
        .i_phy_data          (i_phy_data),
        .i_signal_ok         (i_signal_ok),
        .i_idle_pattern_mode (i_idle_pattern_mode),
        .i_read_lock_status  (i_read_lock_status),
        .i_read_mismatch     (i_read_mismatch),
        .o_lane_lock         (o_lane_lock),
        .o_lock_status       (o_lock_status),
        .o_mismatch_count    (o_mismatch_count),
        .o_rx_ok             (o_rx_ok)
    );

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "stopped at the first failure");
    endtask

    // taps 32 22 2 1, one step per bit
    function automatic logic [31:0] random_bits(input int nb_bits);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int b = 0; b < nb_bits; b++)
        begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    // each lane hit with chance 2^-nb_bits, none for zero
    function automatic logic [N_LANES-1:0] random_lane_mask(input int nb_bits);
        logic [N_LANES-1:0] mask;
        mask = '0;
        for (int lane = 0; lane < N_LANES; lane++)
        begin
            if (nb_bits > 0)
            begin
                mask[lane] = (random_bits(nb_bits) == 32'd0);
            end
        end
        return mask;
    endfunction

    // one rising edge of the model, using the inputs the DUT samples
    task automatic update_model();
        int   addend;
        int   lanes;
        logic header_ok;
        if (reset)
        begin
            m_lock            = '0;
            m_lock_status     = '0;
            m_count           = 0;
            m_chk_valid       = 1'b0;
            m_read_lock_d     = 1'b0;
            m_read_mismatch_d = 1'b0;
            for (int lane = 0; lane < N_LANES; lane++)
            begin
                m_valid_count[lane]   = 0;
                m_window_count[lane]  = 0;
                m_invalid_count[lane] = 0;
            end
        end
        else
        begin
            addend = m_chk_valid ? m_chk_lanes : 0;
            if (i_read_mismatch && !m_read_mismatch_d)
                m_count = addend;
            else
                m_count = (m_count + addend > COUNT_MAX) ? COUNT_MAX : m_count + addend;
            if (i_read_lock_status && !m_read_lock_d)
                m_lock_status = m_lock;
            else
                m_lock_status = m_lock_status & m_lock;
            m_read_lock_d     = i_read_lock_status;
            m_read_mismatch_d = i_read_mismatch;
            m_chk_valid       = i_valid && i_idle_pattern_mode;
            lanes = 0;
            for (int lane = 0; lane < N_LANES; lane++)
            begin
                if (i_phy_data[lane].payload != IDLE_WORD)
                    lanes++;
            end
            if (i_valid)
                m_chk_lanes = lanes;
            for (int lane = 0; lane < N_LANES; lane++)
            begin
                header_ok = (i_phy_data[lane].sync_header == 2'b01) ||
                            (i_phy_data[lane].sync_header == 2'b10);
                if (!i_signal_ok)
                begin
                    m_lock[lane]          = 1'b0;
                    m_valid_count[lane]   = 0;
                    m_window_count[lane]  = 0;
                    m_invalid_count[lane] = 0;
                end
                else if (i_valid && !m_lock[lane])
                begin
                    m_valid_count[lane] = header_ok ? m_valid_count[lane] + 1 : 0;
                    if (m_valid_count[lane] == LOCK_BLOCKS)
                    begin
                        m_lock[lane]        = 1'b1;
                        m_valid_count[lane] = 0;
                    end
                end
                else if (i_valid)
                begin
                    m_window_count[lane]  = m_window_count[lane] + 1;
                    m_invalid_count[lane] = m_invalid_count[lane] + (header_ok ? 0 : 1);
                    if (m_invalid_count[lane] == INVALID_LIMIT)
                        m_lock[lane] = 1'b0;
                    if ((m_invalid_count[lane] == INVALID_LIMIT) ||
                        (m_window_count[lane] == WINDOW_BLOCKS))
                    begin
                        m_window_count[lane]  = 0;
                        m_invalid_count[lane] = 0;
                    end
                end
            end
        end
    endtask

    task automatic check_outputs();
        assert (o_lane_lock === m_lock) else
            report_failure($sformatf("error: test %s, o_lane_lock expected %b actual %b",
                test_name, m_lock, o_lane_lock));
        assert (o_lock_status === m_lock_status) else
            report_failure($sformatf("error: test %s, o_lock_status expected %b actual %b",
                test_name, m_lock_status, o_lock_status));
        assert (o_mismatch_count === mismatch_count_t'(m_count)) else
            report_failure($sformatf("error: test %s, o_mismatch_count expected %0d actual %0d",
                test_name, m_count, o_mismatch_count));
        assert (o_rx_ok === ((&m_lock_status) && (m_count == 0))) else
            report_failure($sformatf("error: test %s, o_rx_ok expected %b actual %b",
                test_name, (&m_lock_status) && (m_count == 0), o_rx_ok));
    endtask

    // model at the edge, drive the next inputs, compare at the falling edge
    task automatic run_cycle(input logic valid, input logic [N_LANES-1:0] bad_headers,
                             input logic [N_LANES-1:0] bad_payloads);
        block_t [N_LANES-1:0] blocks;
        logic [5:0]           flip;
        @(posedge clock);
        update_model();
        for (int lane = 0; lane < N_LANES; lane++)
        begin
            blocks[lane].sync_header = (random_bits(1) != 32'd0) ? SH_CTRL : SH_DATA;
            if (bad_headers[lane])
                blocks[lane].sync_header = (random_bits(1) != 32'd0) ? 2'b11 : 2'b00;
            blocks[lane].payload = IDLE_WORD;
            if (bad_payloads[lane])
            begin
                flip                 = 6'(random_bits(6));
                blocks[lane].payload = IDLE_WORD ^ (64'd1 << flip);
            end
        end
        i_valid             <= valid;
        i_phy_data          <= blocks;
        i_signal_ok         <= stim_signal_ok;
        i_idle_pattern_mode <= stim_idle_mode;
        i_read_lock_status  <= stim_read_lock;
        i_read_mismatch     <= stim_read_mismatch;
        @(negedge clock);
        check_outputs();
    endtask

    // about one valid in four left out
    task automatic random_cycles(input int count, input int header_bits, input int payload_bits);
        logic               valid;
        logic [N_LANES-1:0] bad_headers;
        logic [N_LANES-1:0] bad_payloads;
        for (int c = 0; c < count; c++)
        begin
            valid        = (random_bits(2) != 32'd0);
            bad_headers  = random_lane_mask(header_bits);
            bad_payloads = random_lane_mask(payload_bits);
            run_cycle(valid, bad_headers, bad_payloads);
        end
    endtask

    task automatic read_lock_status_once();
        stim_read_lock = 1'b1;
        random_cycles(1, 0, 0);
        stim_read_lock = 1'b0;
    endtask

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
            report_failure("timeout: the tests did not finish within the cycle limit");
    end

    initial
    begin
        mismatch_count_t saved_count;
        lfsr_state          = LFSR_SEED;
        stim_signal_ok      = 1'b1;
        stim_idle_mode      = 1'b0;
        stim_read_lock      = 1'b0;
        stim_read_mismatch  = 1'b0;
        i_valid             = 1'b0;
        i_signal_ok         = 1'b1;
        i_idle_pattern_mode = 1'b0;
        i_read_lock_status  = 1'b0;
        i_read_mismatch     = 1'b0;
        for (int lane = 0; lane < N_LANES; lane++)
            i_phy_data[lane] = {SH_CTRL, IDLE_WORD};
        test_name = "reset";
        repeat (3) run_cycle(1'b0, '0, '0);

        test_name = "lock_acquisition";
        random_cycles(300, 5, 0);
        random_cycles(60, 0, 0);
        assert (o_lane_lock === '1) else
            report_failure("lock_acquisition: not every lane reached lock on clean headers");
        read_lock_status_once();

        test_name = "lock_loss";
        for (int lane = 0; lane < N_LANES; lane++)
        begin
            while (m_lock[lane])
                run_cycle(1'b1, N_LANES'(1 << lane), '0);
            // the clean lanes keep their lock
            assert ((o_lane_lock | N_LANES'(1 << lane)) === '1) else
                report_failure("lock_loss: a lane with clean headers lost lock");
            while (!m_lock[lane])
                random_cycles(1, 0, 0);
            random_cycles(2, 0, 0);
            assert (o_lock_status[lane] === 1'b0) else
                report_failure("lock_loss: lock status rose again before a read");
            read_lock_status_once();
            random_cycles(2, 0, 0);
        end

        test_name = "mismatch_count";
        stim_idle_mode = 1'b1;
        random_cycles(2000, 0, 3);

        test_name = "clear_on_read";
        repeat (20)
        begin
            random_cycles(10 + int'(random_bits(5)), 0, 3);
            stim_read_mismatch = 1'b1;
            random_cycles(1 + int'(random_bits(2)), 0, 3);
            stim_read_mismatch = 1'b0;
        end

        test_name = "gating_idle_mode";
        stim_idle_mode = 1'b0;
        random_cycles(4, 0, 0);
        saved_count = mismatch_count_t'(m_count);
        random_cycles(300, 0, 1);
        assert (o_mismatch_count === saved_count) else
            report_failure($sformatf("error: test %s, o_mismatch_count expected %0d actual %0d",
                test_name, saved_count, o_mismatch_count));

        test_name = "gating_signal_ok";
        stim_signal_ok = 1'b0;
        run_cycle(1'b1, '0, '0);
        run_cycle(1'b1, '0, '0);
        assert (o_lane_lock === '0) else
            report_failure("gating_signal_ok: a lane kept lock with the signal gone");
        stim_signal_ok = 1'b1;
        random_cycles(80, 0, 0);
        stim_read_mismatch = 1'b1;
        read_lock_status_once();
        stim_read_mismatch = 1'b0;
        random_cycles(3, 0, 0);
        assert (o_rx_ok === 1'b1) else
            report_failure("gating_signal_ok: receive path not reported ok after relock and reads");

        $display("Verification passed");
        $finish;
    end

endmodule
